/* mul_simd_config.svh */
////////////////////////////////////////
// Widths and saturation constants of the
// packed SIMD multiplier datapath
////////////////////////////////////////
`ifndef MUL_SIMD_CONFIG_SVH
`define MUL_SIMD_CONFIG_SVH

// Word, lane and halfword widths
`define MUL_XLEN    32
`define MUL_LANE_W  8
`define MUL_HALF_W  16
`define MUL_LANES   (`MUL_XLEN / `MUL_LANE_W)

// Kernel operand is a byte plus its sign bit
`define MUL_KERN_W  (`MUL_LANE_W + 1)
`define MUL_PAIRS   8
`define MUL_BPROD_W 17

// One 32x16 product
`define MUL_IMD_W   48

// Saturation values
`define MUL_Q7_MAX  8'h7f
`define MUL_Q15_MAX 16'h7fff

`endif

/* mul_isa_pkg.sv */
////////////////////////////////////////
// Instruction-level types: opcodes and
// the result selection of the multiplier
////////////////////////////////////////
`default_nettype none

package mul_isa_pkg;

  // Supported multiply operations
  typedef enum logic [3:0] {
    MUL    = 4'd0,
    MULH   = 4'd1,
    MULHU  = 4'd2,
    KHM8   = 4'd3,
    KHM16  = 4'd4,
    SMBB16 = 4'd5,
    SMTT16 = 4'd6,
    SMAQA  = 4'd7,
    UMAQA  = 4'd8
  } mul_op_e;

  // Result register source, HU zero-extends the intermediate
  typedef enum logic [2:0] {
    RES_Q7, RES_Q15, RES_BB, RES_TT, RES_MAQA, RES_LO, RES_HI, RES_HU
  } res_sel_e;

endpackage

`default_nettype wire

/* mul_dp_pkg.sv */
////////////////////////////////////////
// Datapath types: kernel configuration
// and sequencer states
////////////////////////////////////////
`default_nettype none

package mul_dp_pkg;

  // How the eight byte kernels are grouped
  typedef enum logic [1:0] {
    M8X8   = 2'd0,
    M16X16 = 2'd1,
    M32X16 = 2'd2
  } lane_mode_e;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    LOWER = 2'd1,
    UPPER = 2'd2,
    DONE  = 2'd3
  } mul_state_e;

endpackage

`default_nettype wire

/* mul_op_decoder.sv */
////////////////////////////////////////
// Opcode register and decode into the
// kernel mode, signedness and result source
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mul_op_decoder
  import mul_isa_pkg::*;
  import mul_dp_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       load_i,
  input  mul_op_e    op_i,
  output lane_mode_e mode_o,
  output logic       sign_a_o,
  output logic       sign_b_o,
  output logic       two_pass_o,
  output res_sel_e   res_sel_o
);

  mul_op_e op_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q <= MUL;
    end else if (load_i) begin
      op_q <= op_i;
    end
  end

  // Signed byte mode unless the opcode says otherwise
  always_comb begin
    mode_o     = M8X8;
    sign_a_o   = 1'b1;
    sign_b_o   = 1'b1;
    two_pass_o = 1'b0;
    res_sel_o  = RES_Q7;
    unique case (op_q)
      MUL: begin
        mode_o     = M32X16;
        two_pass_o = 1'b1;
        res_sel_o  = RES_LO;
      end
      MULH: begin
        mode_o     = M32X16;
        two_pass_o = 1'b1;
        res_sel_o  = RES_HI;
      end
      MULHU: begin
        mode_o     = M32X16;
        sign_a_o   = 1'b0;
        sign_b_o   = 1'b0;
        two_pass_o = 1'b1;
        res_sel_o  = RES_HU;
      end
      KHM16: begin
        mode_o    = M16X16;
        res_sel_o = RES_Q15;
      end
      SMBB16: begin
        mode_o    = M16X16;
        res_sel_o = RES_BB;
      end
      SMTT16: begin
        mode_o    = M16X16;
        res_sel_o = RES_TT;
      end
      SMAQA: res_sel_o = RES_MAQA;
      UMAQA: begin
        sign_a_o  = 1'b0;
        sign_b_o  = 1'b0;
        res_sel_o = RES_MAQA;
      end
      default: res_sel_o = RES_Q7;
    endcase
  end

endmodule

`default_nettype wire

/* mul_seq_ctrl.sv */
////////////////////////////////////////
// Sequencer FSM: capture, pass strobes
// and the valid/busy levels to the consumer
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mul_seq_ctrl
  import mul_dp_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  logic       ready_i,
  input  logic       two_pass_i,
  output logic       load_o,
  output logic       imd_we_o,
  output logic       res_we_o,
  output logic       valid_o,
  output logic       busy_o,
  output mul_state_e state_o
);

  mul_state_e state_q, state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d  = state_q;
    load_o   = 1'b0;
    imd_we_o = 1'b0;
    res_we_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        // Starts are only taken here
        if (start_i) begin
          load_o  = 1'b1;
          state_d = LOWER;
        end
      end
      LOWER: begin
        if (two_pass_i) begin
          imd_we_o = 1'b1;
          state_d  = UPPER;
        end else begin
          res_we_o = 1'b1;
          state_d  = DONE;
        end
      end
      UPPER: begin
        res_we_o = 1'b1;
        state_d  = DONE;
      end
      DONE: begin
        // Hold the result under back-pressure
        if (ready_i) begin
          state_d = IDLE;
        end
      end
    endcase
  end

  assign valid_o = (state_q == DONE);
  assign busy_o  = (state_q != IDLE);
  assign state_o = state_q;

endmodule

`default_nettype wire

/* mul_operand_steer.sv */
////////////////////////////////////////
// Operand registers and byte steering to
// the eight 9x9 kernels, with sign decode
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "mul_simd_config.svh"

module mul_operand_steer
  import mul_dp_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    load_i,
  input  logic [`MUL_XLEN-1:0]                    op_a_i,
  input  logic [`MUL_XLEN-1:0]                    op_b_i,
  input  lane_mode_e                              mode_i,
  input  mul_state_e                              state_i,
  input  logic                                    sign_a_i,
  input  logic                                    sign_b_i,
  output logic [`MUL_PAIRS-1:0][`MUL_KERN_W-1:0]  kern_a_o,
  output logic [`MUL_PAIRS-1:0][`MUL_KERN_W-1:0]  kern_b_o
);

  logic [`MUL_XLEN-1:0]            op_a_q, op_b_q;
  logic [1:0][`MUL_HALF_W-1:0]     b_half;
  logic                            b_signed;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_a_q <= '0;
      op_b_q <= '0;
    end else if (load_i) begin
      op_a_q <= op_a_i;
      op_b_q <= op_b_i;
    end
  end

  // Halfword of op_b seen by each kernel
  always_comb begin
    if (mode_i == M32X16) begin
      b_half[0] = (state_i == UPPER) ? op_b_q[31:16] : op_b_q[15:0];
      b_half[1] = b_half[0];
    end else begin
      b_half[0] = op_b_q[15:0];
      b_half[1] = op_b_q[31:16];
    end
  end

  // Low halfword of a 32x32 multiply is always unsigned
  assign b_signed = sign_b_i & ~((mode_i == M32X16) & (state_i != UPPER));

  ////////////////////////////////////////
  // Pair k: kernel k/4, a byte (k%4)/2, b byte k%2
  for (genvar k = 0; k < `MUL_PAIRS; k++) begin : g_pair
    localparam int H  = k / 4;
    localparam int AI = 2 * H + (k % 4) / 2;
    localparam int BI = k % 2;
    logic [`MUL_LANE_W-1:0] a_byte, b_byte;
    logic                   a_top, b_top;

    assign a_byte = op_a_q[AI*`MUL_LANE_W +: `MUL_LANE_W];
    assign b_byte = b_half[H][BI*`MUL_LANE_W +: `MUL_LANE_W];

    // Only the top byte of each operand carries a sign
    always_comb begin
      unique case (mode_i)
        M8X8:    a_top = 1'b1;
        M16X16:  a_top = (AI % 2 == 1);
        default: a_top = (AI == 3);
      endcase
    end
    assign b_top = (mode_i == M8X8) || (BI == 1);

    assign kern_a_o[k] = {sign_a_i & a_top & a_byte[`MUL_LANE_W-1], a_byte};
    assign kern_b_o[k] = {b_signed & b_top & b_byte[`MUL_LANE_W-1], b_byte};
  end

endmodule

`default_nettype wire

/* mul_kernel_array.sv */
////////////////////////////////////////
// Eight signed 9x9 multipliers with the
// 16x16 kernel adders and the 32x16 combine
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "mul_simd_config.svh"

module mul_kernel_array
  import mul_dp_pkg::*;
(
  input  logic [`MUL_PAIRS-1:0][`MUL_KERN_W-1:0]  kern_a_i,
  input  logic [`MUL_PAIRS-1:0][`MUL_KERN_W-1:0]  kern_b_i,
  input  lane_mode_e                              lane_mode_i,
  output logic [`MUL_LANES-1:0][`MUL_BPROD_W-1:0] byte_prod_o,
  output logic [1:0][`MUL_XLEN-1:0]               half_prod_o,
  output logic [`MUL_IMD_W-1:0]                   wide_prod_o
);

  localparam int PP_W = 2 * `MUL_KERN_W;
  localparam int HF_W = 2 * `MUL_HALF_W + 2;

  logic signed [PP_W-1:0]  pp [`MUL_PAIRS];
  logic signed [HF_W-1:0]  half_full [2];
  logic [`MUL_IMD_W-1:0]   wide_full;

  for (genvar k = 0; k < `MUL_PAIRS; k++) begin : g_mult
    assign pp[k] = $signed(kern_a_i[k]) * $signed(kern_b_i[k]);
  end

  // 16x16 per kernel: lo*lo + (lo*hi + hi*lo) << 8 + hi*hi << 16
  for (genvar h = 0; h < 2; h++) begin : g_half
    assign half_full[h] = HF_W'(pp[4*h])
                        + (HF_W'(pp[4*h+1]) <<< `MUL_LANE_W)
                        + (HF_W'(pp[4*h+2]) <<< `MUL_LANE_W)
                        + (HF_W'(pp[4*h+3]) <<< `MUL_HALF_W);
  end

  // Upper kernel carries the top halfword of op_a
  assign wide_full = `MUL_IMD_W'(half_full[0])
                   + (`MUL_IMD_W'(half_full[1]) <<< `MUL_HALF_W);

  ////////////////////////////////////////
  // Product groups not used by the mode stay at zero
  always_comb begin
    byte_prod_o = '0;
    half_prod_o = '0;
    wide_prod_o = '0;
    unique case (lane_mode_i)
      M8X8: begin
        byte_prod_o[0] = pp[0][`MUL_BPROD_W-1:0];
        byte_prod_o[1] = pp[3][`MUL_BPROD_W-1:0];
        byte_prod_o[2] = pp[4][`MUL_BPROD_W-1:0];
        byte_prod_o[3] = pp[7][`MUL_BPROD_W-1:0];
      end
      M16X16: begin
        half_prod_o[0] = half_full[0][`MUL_XLEN-1:0];
        half_prod_o[1] = half_full[1][`MUL_XLEN-1:0];
      end
      default: wide_prod_o = wide_full;
    endcase
  end

endmodule

`default_nettype wire

/* mul_result_unit.sv */
////////////////////////////////////////
// Accumulator and intermediate registers,
// saturation, MAC and 32x32 combine, result register
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "mul_simd_config.svh"

module mul_result_unit
  import mul_isa_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    load_i,
  input  logic                                    imd_we_i,
  input  logic                                    res_we_i,
  input  logic [`MUL_XLEN-1:0]                    rd_i,
  input  res_sel_e                                res_sel_i,
  input  logic [`MUL_LANES-1:0][`MUL_BPROD_W-1:0] byte_prod_i,
  input  logic [1:0][`MUL_XLEN-1:0]               half_prod_i,
  input  logic [`MUL_IMD_W-1:0]                   wide_prod_i,
  output logic [`MUL_XLEN-1:0]                    result_o,
  output logic                                    ov_o
);

  localparam int EXT_W = `MUL_XLEN - `MUL_BPROD_W;

  logic [`MUL_XLEN-1:0]   rd_q, q7_res, q15_res, maqa_sum, lo_word, res_d;
  logic [`MUL_IMD_W-1:0]  imd_q, hi_sum;
  logic [`MUL_LANES-1:0]  sat8;
  logic [1:0]             sat16;
  logic                   imd_ext, ov_d;

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      rd_q <= rd_i;
    end
    if (imd_we_i) begin
      imd_q <= wide_prod_i;
    end
  end

  ////////////////////////////////////////
  // Saturation, only -1.0 * -1.0 overflows
  always_comb begin
    for (int i = 0; i < `MUL_LANES; i++) begin
      sat8[i] = (byte_prod_i[i] == 17'h04000);
      q7_res[i*`MUL_LANE_W +: `MUL_LANE_W] = sat8[i] ? `MUL_Q7_MAX : byte_prod_i[i][14:7];
    end
    for (int i = 0; i < 2; i++) begin
      sat16[i] = (half_prod_i[i] == 32'h4000_0000);
      q15_res[i*`MUL_HALF_W +: `MUL_HALF_W] = sat16[i] ? `MUL_Q15_MAX : half_prod_i[i][30:15];
    end
  end

  // Quad-byte MAC, wraps modulo 2^32
  always_comb begin
    maqa_sum = rd_q;
    for (int i = 0; i < `MUL_LANES; i++) begin
      maqa_sum = maqa_sum + {{EXT_W{byte_prod_i[i][`MUL_BPROD_W-1]}}, byte_prod_i[i]};
    end
  end

  ////////////////////////////////////////
  // 32x32 combine: lower pass + upper pass << 16
  assign lo_word = imd_q[31:0] + {wide_prod_i[15:0], 16'h0};
  assign imd_ext = (res_sel_i == RES_HU) ? 1'b0 : imd_q[`MUL_IMD_W-1];
  assign hi_sum  = {{16{imd_ext}}, imd_q[`MUL_IMD_W-1:16]} + wide_prod_i;

  always_comb begin
    ov_d = 1'b0;
    unique case (res_sel_i)
      RES_Q7: begin
        res_d = q7_res;
        ov_d  = |sat8;
      end
      RES_Q15: begin
        res_d = q15_res;
        ov_d  = |sat16;
      end
      RES_BB:   res_d = half_prod_i[0];
      RES_TT:   res_d = half_prod_i[1];
      RES_MAQA: res_d = maqa_sum;
      RES_LO:   res_d = lo_word;
      // Signed and unsigned high word
      default:  res_d = hi_sum[`MUL_IMD_W-1:16];
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ov_o <= 1'b0;
    end else if (res_we_i) begin
      ov_o <= ov_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_we_i) begin
      result_o <= res_d;
    end
  end

endmodule

`default_nettype wire

/* mul_simd_top.sv */
////////////////////////////////////////
// Packed SIMD multiplier top level, start
// pulse in, result held under valid/ready
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "mul_simd_config.svh"

module mul_simd_top
  import mul_isa_pkg::*;
  import mul_dp_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  mul_op_e              op_i,
  input  logic [`MUL_XLEN-1:0] op_a_i,
  input  logic [`MUL_XLEN-1:0] op_b_i,
  input  logic [`MUL_XLEN-1:0] rd_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output logic                 busy_o,
  output logic [`MUL_XLEN-1:0] result_o,
  output logic                 ov_o
);

  logic                                    load, imd_we, res_we;
  logic                                    sign_a, sign_b, two_pass;
  mul_state_e                              state;
  lane_mode_e                              mode;
  res_sel_e                                res_sel;
  logic [`MUL_PAIRS-1:0][`MUL_KERN_W-1:0]  kern_a, kern_b;
  logic [`MUL_LANES-1:0][`MUL_BPROD_W-1:0] byte_prod;
  logic [1:0][`MUL_XLEN-1:0]               half_prod;
  logic [`MUL_IMD_W-1:0]                   wide_prod;

  mul_seq_ctrl u_seq_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .ready_i    (ready_i),
    .two_pass_i (two_pass),
    .load_o     (load),
    .imd_we_o   (imd_we),
    .res_we_o   (res_we),
    .valid_o    (valid_o),
    .busy_o     (busy_o),
    .state_o    (state)
  );

  mul_op_decoder u_op_decoder (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (load),
    .op_i       (op_i),
    .mode_o     (mode),
    .sign_a_o   (sign_a),
    .sign_b_o   (sign_b),
    .two_pass_o (two_pass),
    .res_sel_o  (res_sel)
  );

  mul_operand_steer u_operand_steer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .load_i   (load),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .mode_i   (mode),
    .state_i  (state),
    .sign_a_i (sign_a),
    .sign_b_i (sign_b),
    .kern_a_o (kern_a),
    .kern_b_o (kern_b)
  );

  mul_kernel_array u_kernel_array (
    .kern_a_i    (kern_a),
    .kern_b_i    (kern_b),
    .lane_mode_i (mode),
    .byte_prod_o (byte_prod),
    .half_prod_o (half_prod),
    .wide_prod_o (wide_prod)
  );

  mul_result_unit u_result_unit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (load),
    .imd_we_i    (imd_we),
    .res_we_i    (res_we),
    .rd_i        (rd_i),
    .res_sel_i   (res_sel),
    .byte_prod_i (byte_prod),
    .half_prod_i (half_prod),
    .wide_prod_i (wide_prod),
    .result_o    (result_o),
    .ov_o        (ov_o)
  );

endmodule

`default_nettype wire

/* mul_simd_properties.sv */
////////////////////////////////////////
// Control protocol assertions, bound
// into the multiplier top level
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mul_simd_properties (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        start_i,
  input logic        ready_i,
  input logic        valid_o,
  input logic        busy_o,
  input logic [31:0] result_o,
  input logic        ov_o
);

  int unsigned fail_count = 0;
  logic        start_seen;

  // Accepted start still waiting for its transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_seen <= 1'b0;
    end else if (start_i && !busy_o) begin
      start_seen <= 1'b1;
    end else if (valid_o && ready_i) begin
      start_seen <= 1'b0;
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i) $rose(rst_ni) |-> !valid_o && !busy_o)
    else begin
      fail_count++;
      $error("valid_o or busy_o high in the first cycle after reset");
    end

  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> $stable(result_o) && $stable(ov_o))
    else begin
      fail_count++;
      $error("Result changed while held under back-pressure");
    end

  a_valid_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(valid_o) |-> start_seen)
    else begin
      fail_count++;
      $error("valid_o rose without an accepted start");
    end

endmodule

bind mul_simd_top mul_simd_properties u_props (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .start_i  (start_i),
  .ready_i  (ready_i),
  .valid_o  (valid_o),
  .busy_o   (busy_o),
  .result_o (result_o),
  .ov_o     (ov_o)
);

`default_nettype wire

/* tb_mul_simd.sv */
////////////////////////////////////////
// Directed testbench of the packed SIMD
// multiplier, one task per operation group
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_mul_simd
  import mul_isa_pkg::*;
();

  localparam int unsigned SEED    = 32'h6ab4;
  localparam int          TIMEOUT = 40;

  logic        clk_i, rst_ni, start_i, ready_i;
  mul_op_e     op_i;
  logic [31:0] op_a_i, op_b_i, rd_i;
  logic        valid_o, busy_o, ov_o;
  logic [31:0] result_o;

  // Response captured when valid_o is first seen
  logic [31:0] got_res;
  logic        got_ov;
  int          got_cycles;

  mul_simd_top dut (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .op_i     (op_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .rd_i     (rd_i),
    .ready_i  (ready_i),
    .valid_o  (valid_o),
    .busy_o   (busy_o),
    .result_o (result_o),
    .ov_o     (ov_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  ////////////////////////////////////////
  // Reference model

  // Q7 or Q15 lanes, only -1.0 * -1.0 saturates
  function automatic logic [32:0] sat_lanes(logic [31:0] a, logic [31:0] b, bit half);
    logic [31:0] res;
    logic        ov;
    longint      p;
    res = '0;
    ov  = 1'b0;
    if (!half) begin
      for (int i = 0; i < 4; i++) begin
        p = $signed(a[8*i +: 8]) * $signed(b[8*i +: 8]);
        res[8*i +: 8] = (p == 16384) ? 8'h7f : 8'(p >>> 7);
        ov = ov | (p == 16384);
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        p = $signed(a[16*i +: 16]) * $signed(b[16*i +: 16]);
        res[16*i +: 16] = (p == 64'sd1073741824) ? 16'h7fff : 16'(p >>> 15);
        ov = ov | (p == 64'sd1073741824);
      end
    end
    return {ov, res};
  endfunction

  function automatic logic [31:0] quad_mac_sum(logic [31:0] a, logic [31:0] b,
                                               logic [31:0] rd, bit sgn);
    logic [31:0] sum;
    int          p;
    sum = rd;
    for (int i = 0; i < 4; i++) begin
      if (sgn) begin
        p = $signed(a[8*i +: 8]) * $signed(b[8*i +: 8]);
      end else begin
        p = a[8*i +: 8] * b[8*i +: 8];
      end
      sum = sum + p;
    end
    return sum;
  endfunction

  function automatic logic [31:0] wide_product(mul_op_e op, logic [31:0] a, logic [31:0] b);
    logic [63:0] p;
    if (op == MULHU) begin
      p = {32'd0, a} * {32'd0, b};
    end else begin
      p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    end
    return (op == MUL) ? p[31:0] : p[63:32];
  endfunction

  function automatic logic [32:0] expected_result(mul_op_e op, logic [31:0] a,
                                                  logic [31:0] b, logic [31:0] rd);
    logic [31:0] w;
    case (op)
      KHM8:  return sat_lanes(a, b, 1'b0);
      KHM16: return sat_lanes(a, b, 1'b1);
      SMBB16: begin
        w = $signed(a[15:0]) * $signed(b[15:0]);
        return {1'b0, w};
      end
      SMTT16: begin
        w = $signed(a[31:16]) * $signed(b[31:16]);
        return {1'b0, w};
      end
      SMAQA:   return {1'b0, quad_mac_sum(a, b, rd, 1'b1)};
      UMAQA:   return {1'b0, quad_mac_sum(a, b, rd, 1'b0)};
      default: return {1'b0, wide_product(op, a, b)};
    endcase
  endfunction

  ////////////////////////////////////////
  // Start one op, hold ready_i low for hold cycles, then transfer
  task automatic run_op(string name, mul_op_e op, logic [31:0] a, logic [31:0] b,
                        logic [31:0] rd, int hold);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    @(posedge clk_i);
    start_i <= 1'b1;
    op_i    <= op;
    op_a_i  <= a;
    op_b_i  <= b;
    rd_i    <= rd;
    while (!seen) begin
      @(posedge clk_i);
      start_i <= 1'b0;
      cycles++;
      @(negedge clk_i);
      seen = valid_o;
      if (!seen && cycles >= TIMEOUT) begin
        $display("Timeout: valid_o never rose in %s", name);
        stop_run();
      end
    end
    got_res    = result_o;
    got_ov     = ov_o;
    got_cycles = cycles;
    check_word({name, " busy"}, 32'd1, {31'd0, busy_o});
    // A start while busy must leave the held result alone
    for (int i = 0; i < hold; i++) begin
      @(posedge clk_i);
      start_i <= (i == 0);
      op_i    <= KHM8;
      op_a_i  <= $urandom();
      op_b_i  <= $urandom();
      @(negedge clk_i);
      check_word({name, " held result"}, got_res, result_o);
      check_word({name, " held ov"}, {31'd0, got_ov}, {31'd0, ov_o});
      check_word({name, " held valid"}, 32'd1, {31'd0, valid_o});
    end
    @(posedge clk_i);
    start_i <= 1'b0;
    ready_i <= 1'b1;
    @(posedge clk_i);
    ready_i <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      if (busy_o && cycles >= TIMEOUT) begin
        $display("Timeout: busy_o stayed high after the transfer in %s", name);
        stop_run();
      end
    end while (busy_o);
  endtask

  task automatic verify_op(string name, mul_op_e op, logic [31:0] a, logic [31:0] b,
                           logic [31:0] rd, int hold);
    logic [32:0] exp;
    int          exp_cycles;
    exp        = expected_result(op, a, b, rd);
    exp_cycles = (op == MUL || op == MULH || op == MULHU) ? 3 : 2;
    run_op(name, op, a, b, rd, hold);
    check_word({name, " result"}, exp[31:0], got_res);
    check_word({name, " ov"}, {31'd0, exp[32]}, {31'd0, got_ov});
    check_word({name, " latency"}, exp_cycles, got_cycles);
  endtask

  ////////////////////////////////////////
  // Directed tests

  task automatic khm_cases();
    for (int i = 0; i < 8; i++) begin
      verify_op("khm8_rand", KHM8, $urandom(), $urandom(), 32'd0, 0);
      verify_op("khm16_rand", KHM16, $urandom(), $urandom(), 32'd0, 0);
    end
    verify_op("khm8_sat", KHM8, 32'h8012_807f, 32'h8080_0180, 32'd0, 0);
    verify_op("khm8_all_sat", KHM8, 32'h8080_8080, 32'h8080_8080, 32'd0, 0);
    verify_op("khm16_sat", KHM16, 32'h8000_8000, 32'h8000_7fff, 32'd0, 0);
  endtask

  task automatic halfword_cases();
    for (int i = 0; i < 6; i++) begin
      verify_op("smbb16_rand", SMBB16, $urandom(), $urandom(), 32'd0, 0);
      verify_op("smtt16_rand", SMTT16, $urandom(), $urandom(), 32'd0, 0);
    end
    verify_op("smbb16_min", SMBB16, 32'h1234_8000, 32'h5678_8000, 32'd0, 0);
    verify_op("smtt16_min", SMTT16, 32'h8000_0001, 32'h7fff_ffff, 32'd0, 0);
  endtask

  task automatic mac_cases();
    for (int i = 0; i < 6; i++) begin
      verify_op("smaqa_rand", SMAQA, $urandom(), $urandom(), $urandom(), 0);
      verify_op("umaqa_rand", UMAQA, $urandom(), $urandom(), $urandom(), 0);
    end
    verify_op("smaqa_wrap", SMAQA, 32'h8080_8080, 32'h8080_8080, 32'hffff_0000, 0);
    verify_op("umaqa_wrap", UMAQA, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 0);
  endtask

  task automatic wide_cases();
    logic [31:0] corner [4];
    corner[0] = 32'h8000_0000;
    corner[1] = 32'hffff_ffff;
    corner[2] = 32'h7fff_ffff;
    corner[3] = 32'h0000_0000;
    for (int i = 0; i < 6; i++) begin
      verify_op("mul_rand", MUL, $urandom(), $urandom(), 32'd0, 0);
      verify_op("mulh_rand", MULH, $urandom(), $urandom(), 32'd0, 0);
      verify_op("mulhu_rand", MULHU, $urandom(), $urandom(), 32'd0, 0);
    end
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        verify_op("mul_corner", MUL, corner[i], corner[j], 32'd0, 0);
        verify_op("mulh_corner", MULH, corner[i], corner[j], 32'd0, 0);
        verify_op("mulhu_corner", MULHU, corner[i], corner[j], 32'd0, 0);
      end
    end
  endtask

  task automatic backpressure_cases();
    verify_op("stall_khm8", KHM8, $urandom(), $urandom(), 32'd0, 1 + $urandom_range(7));
    verify_op("stall_mulh", MULH, $urandom(), $urandom(), 32'd0, 1 + $urandom_range(7));
    verify_op("stall_smaqa", SMAQA, $urandom(), $urandom(), $urandom(),
              1 + $urandom_range(7));
    // Op right after a stalled transfer
    verify_op("after_stall", MULHU, $urandom(), $urandom(), 32'd0, 0);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_ni  = 1'b0;
    start_i = 1'b0;
    ready_i = 1'b0;
    op_i    = MUL;
    op_a_i  = '0;
    op_b_i  = '0;
    rd_i    = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    khm_cases();
    halfword_cases();
    mac_cases();
    wide_cases();
    backpressure_cases();
    @(posedge clk_i);
    if (dut.u_props.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("%0d protocol assertion failures", dut.u_props.fail_count);
      $display(">>> FAIL");
      $fatal(1, "Protocol assertions failed");
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
mul_isa_pkg.sv
mul_dp_pkg.sv
mul_op_decoder.sv
mul_seq_ctrl.sv
mul_operand_steer.sv
mul_kernel_array.sv
mul_result_unit.sv
mul_simd_top.sv
mul_simd_properties.sv
tb_mul_simd.sv

/* Bender.yml */
package:
  name: mul_simd

sources:
  - include_dirs:
      - .
    files:
      - mul_isa_pkg.sv
      - mul_dp_pkg.sv
      - mul_op_decoder.sv
      - mul_seq_ctrl.sv
      - mul_operand_steer.sv
      - mul_kernel_array.sv
      - mul_result_unit.sv
      - mul_simd_top.sv
  - target: test
    files:
      - mul_simd_properties.sv
      - tb_mul_simd.sv
